/* common/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address and data geometry
`define DCACHE_ADDR_WIDTH   32
`define DCACHE_DATA_WIDTH   32
`define DCACHE_LINE_WIDTH   128

// Direct-mapped with 64 sets of one 16-byte line
`define DCACHE_NO_OF_SETS   64
`define DCACHE_OFFSET_BITS  4
`define DCACHE_IDX_BITS     6
`define DCACHE_TAG_BITS     22
`define DCACHE_TAG_LSB      10

// Outstanding requests the backing memory can take
`define DCACHE_MEM_CREDITS  1

`endif

/* common/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_WIDTH-1:0]      dcache_addr_t;
    typedef logic [`DCACHE_DATA_WIDTH-1:0]      dcache_word_t;
    typedef logic [`DCACHE_LINE_WIDTH-1:0]      dcache_line_t;

    typedef logic [`DCACHE_TAG_BITS-1:0]        dcache_tag_t;
    typedef logic [`DCACHE_IDX_BITS-1:0]        dcache_idx_t;
    // Word offset within the line, byte bits dropped
    typedef logic [`DCACHE_OFFSET_BITS-3:0]     dcache_offset_t;

    typedef logic [`DCACHE_DATA_WIDTH/8-1:0]    dcache_sel_t;

    typedef struct packed {
        dcache_tag_t tag;
        logic        valid;
        logic        dirty;
    } dcache_tag_entry_t;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        WB_WAIT,
        REFILL,
        REFILL_WAIT,
        FLUSH_CHECK,
        FLUSH_WB,
        FLUSH_WAIT,
        RESPOND
    } dcache_state_e;

endpackage

/* common/dcache_ctrl_if.sv */
`timescale 1ns/1ns

interface dcache_ctrl_if;
    import dcache_pkg::*;

    logic        cache_wr;
    logic        cache_line_wr;
    logic        cache_inval;
    logic        writeback_req;
    logic        flush_mode;
    dcache_idx_t flush_idx;
    logic        cache_hit;
    logic        cache_dirty;

    modport controller (
        output cache_wr,
        output cache_line_wr,
        output cache_inval,
        output writeback_req,
        output flush_mode,
        output flush_idx,
        input  cache_hit,
        input  cache_dirty
    );

    modport datapath (
        input  cache_wr,
        input  cache_line_wr,
        input  cache_inval,
        input  writeback_req,
        input  flush_mode,
        input  flush_idx,
        output cache_hit,
        output cache_dirty
    );

endinterface

/* dcache/dcache_datapath.sv */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_datapath (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    dcache_ctrl_if.datapath         ctrl,
    input  dcache_pkg::dcache_addr_t req_addr_i,
    input  dcache_pkg::dcache_word_t req_wdata_i,
    input  dcache_pkg::dcache_sel_t  req_sel_i,
    input  dcache_pkg::dcache_line_t refill_line_i,
    output dcache_pkg::dcache_word_t rdata_o,
    output dcache_pkg::dcache_line_t wb_line_o,
    output dcache_pkg::dcache_addr_t mem_addr_o
);
    import dcache_pkg::*;

    dcache_tag_entry_t tag_ram [`DCACHE_NO_OF_SETS];
    dcache_line_t      data_ram [`DCACHE_NO_OF_SETS];

    dcache_tag_t       req_tag;
    dcache_idx_t       req_idx;
    dcache_offset_t    req_off;
    dcache_idx_t       set_idx;

    dcache_tag_entry_t set_entry;
    dcache_line_t      set_line;
    dcache_line_t      merged_line;
    dcache_word_t      set_word;
    dcache_word_t      merged_word;
    dcache_word_t      rdata_q;

    assign req_tag = req_addr_i[`DCACHE_ADDR_WIDTH-1:`DCACHE_TAG_LSB];
    assign req_idx = req_addr_i[`DCACHE_TAG_LSB-1:`DCACHE_OFFSET_BITS];
    assign req_off = req_addr_i[`DCACHE_OFFSET_BITS-1:2];

    // A flush walks the sets by its own index
    assign set_idx = ctrl.flush_mode ? ctrl.flush_idx : req_idx;

    assign set_entry = tag_ram[set_idx];
    assign set_line  = data_ram[set_idx];

    always_comb begin
        unique case (req_off)
            2'b00: set_word = set_line[31:0];
            2'b01: set_word = set_line[63:32];
            2'b10: set_word = set_line[95:64];
            2'b11: set_word = set_line[127:96];
            default: set_word = '0;
        endcase
    end

    // Byte lanes not enabled keep the cached value
    always_comb begin
        merged_word = set_word;
        for (int b = 0; b < `DCACHE_DATA_WIDTH/8; b++) begin
            if (req_sel_i[b]) begin
                merged_word[8*b +: 8] = req_wdata_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        merged_line = set_line;
        unique case (req_off)
            2'b00: merged_line[31:0]   = merged_word;
            2'b01: merged_line[63:32]  = merged_word;
            2'b10: merged_line[95:64]  = merged_word;
            2'b11: merged_line[127:96] = merged_word;
            default: merged_line = set_line;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < `DCACHE_NO_OF_SETS; i++) begin
                tag_ram[i].valid <= 1'b0;
                tag_ram[i].dirty <= 1'b0;
            end
        end else if (ctrl.cache_inval) begin
            tag_ram[set_idx].valid <= 1'b0;
            tag_ram[set_idx].dirty <= 1'b0;
        end else if (ctrl.cache_line_wr) begin
            tag_ram[set_idx] <= '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
        end else if (ctrl.cache_wr) begin
            tag_ram[set_idx].dirty <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.cache_line_wr) begin
            data_ram[set_idx] <= refill_line_i;
        end else if (ctrl.cache_wr) begin
            data_ram[set_idx] <= merged_line;
        end
    end

    assign ctrl.cache_hit   = set_entry.valid && (set_entry.tag == req_tag);
    assign ctrl.cache_dirty = set_entry.valid && set_entry.dirty;

    // Victim line address for write-back, request line address for refill
    always_comb begin
        if (ctrl.writeback_req) begin
            mem_addr_o = {set_entry.tag, set_idx, {`DCACHE_OFFSET_BITS{1'b0}}};
        end else begin
            mem_addr_o = {req_tag, req_idx, {`DCACHE_OFFSET_BITS{1'b0}}};
        end
    end

    assign wb_line_o = set_line;

    // Word read during lookup is presented in the response cycle
    always_ff @(posedge clk_i) begin
        rdata_q <= set_word;
    end

    assign rdata_o = rdata_q;

endmodule

/* dcache/dcache_controller.sv */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_controller (
    input  logic              clk_i,
    input  logic              rst_ni,
    dcache_ctrl_if.controller ctrl,
    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  logic              flush_i,
    input  logic              mem_credit_return_i,
    output logic              rsp_valid_o,
    output logic              mem_req_valid_o,
    output logic              mem_we_o,
    output logic              flush_done_o
);
    import dcache_pkg::*;

    localparam int CREDIT_W = $clog2(`DCACHE_MEM_CREDITS + 1);
    localparam dcache_idx_t LAST_IDX = dcache_idx_t'(`DCACHE_NO_OF_SETS - 1);

    dcache_state_e         state_q;
    dcache_state_e         state_d;
    logic                  we_q;
    logic                  lsu_credit_q;
    logic [CREDIT_W-1:0]   mem_credits_q;
    dcache_idx_t           flush_idx_q;
    logic                  flush_done_q;

    logic                  req_accept;
    logic                  mem_ok;
    logic                  flush_step;
    logic                  flush_last;

    // The LSU may only send while it holds the single credit
    assign req_accept = (state_q == IDLE) && req_valid_i && lsu_credit_q;
    assign mem_ok     = (mem_credits_q != '0);
    assign flush_last = (flush_idx_q == LAST_IDX);

    always_comb begin
        state_d            = state_q;
        ctrl.cache_wr      = 1'b0;
        ctrl.cache_line_wr = 1'b0;
        ctrl.cache_inval   = 1'b0;
        ctrl.writeback_req = 1'b0;
        ctrl.flush_mode    = 1'b0;
        rsp_valid_o        = 1'b0;
        mem_req_valid_o    = 1'b0;
        mem_we_o           = 1'b0;
        flush_step         = 1'b0;

        unique case (state_q)
            IDLE: begin
                if (req_accept) begin
                    state_d = LOOKUP;
                end else if (flush_i) begin
                    state_d = FLUSH_CHECK;
                end
            end
            LOOKUP: begin
                if (ctrl.cache_hit) begin
                    ctrl.cache_wr = we_q;
                    state_d       = RESPOND;
                end else if (ctrl.cache_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                ctrl.writeback_req = 1'b1;
                if (mem_ok) begin
                    mem_req_valid_o = 1'b1;
                    mem_we_o        = 1'b1;
                    state_d         = WB_WAIT;
                end
            end
            WB_WAIT: begin
                if (mem_credit_return_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ok) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                // Retry the lookup once the line is in
                if (mem_credit_return_i) begin
                    ctrl.cache_line_wr = 1'b1;
                    state_d            = LOOKUP;
                end
            end
            RESPOND: begin
                rsp_valid_o = 1'b1;
                state_d     = IDLE;
            end
            FLUSH_CHECK: begin
                ctrl.flush_mode = 1'b1;
                if (ctrl.cache_dirty) begin
                    state_d = FLUSH_WB;
                end else begin
                    flush_step = 1'b1;
                end
            end
            FLUSH_WB: begin
                ctrl.flush_mode    = 1'b1;
                ctrl.writeback_req = 1'b1;
                if (mem_ok) begin
                    mem_req_valid_o = 1'b1;
                    mem_we_o        = 1'b1;
                    state_d         = FLUSH_WAIT;
                end
            end
            FLUSH_WAIT: begin
                ctrl.flush_mode = 1'b1;
                flush_step      = mem_credit_return_i;
            end
            default: state_d = IDLE;
        endcase

        // Set done, clear it and move on
        if (flush_step) begin
            ctrl.cache_inval = 1'b1;
            state_d          = flush_last ? IDLE : FLUSH_CHECK;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            lsu_credit_q  <= 1'b1;
            mem_credits_q <= CREDIT_W'(`DCACHE_MEM_CREDITS);
            flush_idx_q   <= '0;
            flush_done_q  <= 1'b0;
        end else begin
            state_q       <= state_d;
            mem_credits_q <= mem_credits_q + CREDIT_W'(mem_credit_return_i)
                             - CREDIT_W'(mem_req_valid_o);
            flush_done_q  <= flush_step && flush_last;
            if (req_accept) begin
                lsu_credit_q <= 1'b0;
            end else if (rsp_valid_o) begin
                lsu_credit_q <= 1'b1;
            end
            // Wraps back to zero after the last set
            if (flush_step) begin
                flush_idx_q <= flush_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            we_q <= req_we_i;
        end
    end

    assign ctrl.flush_idx = flush_idx_q;
    assign flush_done_o   = flush_done_q;

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // LSU side
    input  logic                     lsu_req_valid_i,
    input  dcache_pkg::dcache_addr_t lsu_addr_i,
    input  logic                     lsu_we_i,
    input  dcache_pkg::dcache_word_t lsu_wdata_i,
    input  dcache_pkg::dcache_sel_t  lsu_sel_i,
    output logic                     lsu_rsp_valid_o,
    output dcache_pkg::dcache_word_t lsu_rdata_o,

    input  logic                     dcache_flush_i,
    output logic                     flush_done_o,

    // Memory side
    output logic                     mem_req_valid_o,
    output logic                     mem_we_o,
    output dcache_pkg::dcache_addr_t mem_addr_o,
    output dcache_pkg::dcache_line_t mem_wdata_o,
    input  logic                     mem_rsp_valid_i,
    input  dcache_pkg::dcache_line_t mem_rdata_i
);

    dcache_ctrl_if ctrl_if ();

    dcache_controller u_controller (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .ctrl                (ctrl_if.controller),
        .req_valid_i         (lsu_req_valid_i),
        .req_we_i            (lsu_we_i),
        .flush_i             (dcache_flush_i),
        .mem_credit_return_i (mem_rsp_valid_i),
        .rsp_valid_o         (lsu_rsp_valid_o),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_we_o            (mem_we_o),
        .flush_done_o        (flush_done_o)
    );

    // The LSU holds the address and store data stable until the response
    dcache_datapath u_datapath (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ctrl          (ctrl_if.datapath),
        .req_addr_i    (lsu_addr_i),
        .req_wdata_i   (lsu_wdata_i),
        .req_sel_i     (lsu_sel_i),
        .refill_line_i (mem_rdata_i),
        .rdata_o       (lsu_rdata_o),
        .wb_line_o     (mem_wdata_o),
        .mem_addr_o    (mem_addr_o)
    );

endmodule

/* bench/dcache_mem_model.sv */
`timescale 1ns/1ns

module dcache_mem_model #(
    parameter int LINES     = 256,
    parameter int RSP_DELAY = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     req_valid_i,
    input  logic                     we_i,
    input  dcache_pkg::dcache_addr_t addr_i,
    input  dcache_pkg::dcache_line_t wdata_i,
    output logic                     rsp_valid_o,
    output dcache_pkg::dcache_line_t rdata_o,
    input  dcache_pkg::dcache_addr_t peek_addr_i,
    output dcache_pkg::dcache_line_t peek_line_o
);
    import dcache_pkg::*;

    localparam int LINE_BITS = $clog2(LINES);

    dcache_line_t         mem [LINES];
    logic [LINE_BITS-1:0] line_q;
    logic                 busy_q;
    int                   delay_q;

    function automatic logic [LINE_BITS-1:0] line_of(input dcache_addr_t addr);
        return addr[LINE_BITS+3:4];
    endfunction

    // Reset loads every word with its own byte address
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < LINES; i++) begin
                for (int w = 0; w < 4; w++) begin
                    mem[i][32*w +: 32] <= 32'(i * 16 + w * 4);
                end
            end
            line_q      <= '0;
            busy_q      <= 1'b0;
            delay_q     <= 0;
            rsp_valid_o <= 1'b0;
            rdata_o     <= '0;
        end else begin
            rsp_valid_o <= 1'b0;
            if (req_valid_i) begin
                busy_q  <= 1'b1;
                delay_q <= RSP_DELAY - 1;
                line_q  <= line_of(addr_i);
                if (we_i) begin
                    mem[line_of(addr_i)] <= wdata_i;
                end
            end else if (busy_q) begin
                if (delay_q == 0) begin
                    busy_q      <= 1'b0;
                    rsp_valid_o <= 1'b1;
                    rdata_o     <= mem[line_q];
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
        end
    end

    assign peek_line_o = mem[line_of(peek_addr_i)];

endmodule

/* bench/dcache_tb.sv */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int OPS_PER_PHASE = 150;
    localparam int MISS_CYCLES   = 40;
    localparam int FLUSH_CYCLES  = `DCACHE_NO_OF_SETS * 12;
    localparam int MODEL_LINES   = 256;
    localparam int WATCHDOG_NS   = 4 * ((2 * OPS_PER_PHASE + 1) * MISS_CYCLES
                                        + 2 * (FLUSH_CYCLES + MODEL_LINES) + 64);

    logic         clk;
    logic         rst_n;
    logic         lsu_req_valid;
    dcache_addr_t lsu_addr;
    logic         lsu_we;
    dcache_word_t lsu_wdata;
    dcache_sel_t  lsu_sel;
    logic         lsu_rsp_valid;
    dcache_word_t lsu_rdata;
    logic         flush;
    logic         flush_done;
    logic         mem_req_valid;
    logic         mem_we;
    dcache_addr_t mem_addr;
    dcache_line_t mem_wdata;
    logic         mem_rsp_valid;
    dcache_line_t mem_rdata;
    dcache_addr_t peek_addr;
    dcache_line_t peek_line;

    dcache_word_t shadow [MODEL_LINES*4];
    dcache_tag_t  exp_tag [`DCACHE_NO_OF_SETS];
    logic         exp_valid [`DCACHE_NO_OF_SETS];
    logic         exp_dirty [`DCACHE_NO_OF_SETS];

    // Memory requests seen since the current operation started
    logic         seen_we [$];
    dcache_addr_t seen_addr [$];
    dcache_line_t seen_wdata [$];

    int           req_count;
    int           rsp_count;
    int           mem_pending;
    logic [31:0]  rng_state;
    dcache_addr_t prev_addr;

    dcache_top UUT (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .lsu_req_valid_i (lsu_req_valid),
        .lsu_addr_i      (lsu_addr),
        .lsu_we_i        (lsu_we),
        .lsu_wdata_i     (lsu_wdata),
        .lsu_sel_i       (lsu_sel),
        .lsu_rsp_valid_o (lsu_rsp_valid),
        .lsu_rdata_o     (lsu_rdata),
        .dcache_flush_i  (flush),
        .flush_done_o    (flush_done),
        .mem_req_valid_o (mem_req_valid),
        .mem_we_o        (mem_we),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rdata_i     (mem_rdata)
    );

    dcache_mem_model #(.LINES(MODEL_LINES), .RSP_DELAY(3)) u_mem (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .req_valid_i (mem_req_valid),
        .we_i        (mem_we),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .rsp_valid_o (mem_rsp_valid),
        .rdata_o     (mem_rdata),
        .peek_addr_i (peek_addr),
        .peek_line_o (peek_line)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_value(input string test, input logic [127:0] expected,
                              input logic [127:0] actual);
        $display("** Error [%s] expected %0h, actual %0h", test, expected, actual);
        abort_run();
    endtask

    task automatic fail_plain(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    function automatic dcache_word_t merge_bytes(input dcache_word_t old_word,
                                                 input dcache_word_t new_word,
                                                 input dcache_sel_t sel);
        dcache_word_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    function automatic dcache_line_t shadow_line(input dcache_addr_t line_addr);
        int base;
        base = int'(line_addr[11:4]) * 4;
        return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endfunction

    task automatic do_access(input dcache_addr_t addr, input logic we,
                             input dcache_word_t wdata, input dcache_sel_t sel);
        dcache_tag_t  tag;
        dcache_idx_t  idx;
        int           widx;
        int           lat;
        logic         hit;
        logic         dirty_victim;
        dcache_addr_t victim_addr;
        dcache_word_t expected;
        tag          = addr[31:10];
        idx          = addr[9:4];
        widx         = int'(addr[11:2]);
        hit          = exp_valid[idx] && (exp_tag[idx] == tag);
        dirty_victim = !hit && exp_valid[idx] && exp_dirty[idx];
        victim_addr  = {exp_tag[idx], idx, 4'b0000};
        expected     = shadow[widx];
        seen_we.delete();
        seen_addr.delete();
        seen_wdata.delete();

        lsu_req_valid = 1'b1;
        lsu_addr      = addr;
        lsu_we        = we;
        lsu_wdata     = wdata;
        lsu_sel       = sel;
        req_count++;
        @(posedge clk);
        #1;
        // Address and data stay put until the response
        lsu_req_valid = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!lsu_rsp_valid) begin
            @(posedge clk);
            #1;
            lat++;
            @(negedge clk);
        end

        if (hit) begin
            assert (lat == 2) else fail_value("hit latency", 128'(2), 128'(lat));
            assert (seen_addr.size() == 0)
                else fail_value("hit memory requests", '0, 128'(seen_addr.size()));
        end else begin
            assert (seen_addr.size() == (dirty_victim ? 2 : 1))
                else fail_value("miss memory requests", 128'(dirty_victim ? 2 : 1),
                                128'(seen_addr.size()));
            if (dirty_victim) begin
                assert (seen_we[0] && seen_addr[0] == victim_addr)
                    else fail_value("write-back address", 128'(victim_addr),
                                    128'(seen_addr[0]));
                assert (seen_wdata[0] == shadow_line(victim_addr))
                    else fail_value("write-back data", shadow_line(victim_addr),
                                    seen_wdata[0]);
            end
            assert (!seen_we[seen_we.size()-1] && seen_addr[seen_addr.size()-1] ==
                    {tag, idx, 4'b0000})
                else fail_value("refill address", 128'({tag, idx, 4'b0000}),
                                128'(seen_addr[seen_addr.size()-1]));
        end
        if (!we) begin
            assert (lsu_rdata == expected)
                else fail_value($sformatf("load data @%h", addr), 128'(expected),
                                128'(lsu_rdata));
        end else begin
            shadow[widx] = merge_bytes(shadow[widx], wdata, sel);
        end

        exp_valid[idx] = 1'b1;
        exp_tag[idx]   = tag;
        exp_dirty[idx] = we || (hit && exp_dirty[idx]);
        prev_addr      = addr;
        @(posedge clk);
        #1;
    endtask

    task automatic random_access();
        logic [31:0]  r;
        logic [31:0]  data;
        dcache_tag_t  tag;
        dcache_idx_t  idx;
        next_random(r);
        next_random(data);
        // Half the accesses return to the previous line
        if (r[0]) begin
            tag = prev_addr[31:10];
            idx = prev_addr[9:4];
        end else begin
            tag = dcache_tag_t'(r[15:8] % 8'd3);
            idx = {r[18:16], r[18:16]};
        end
        do_access({tag, idx, r[21:20], 2'b00}, r[26:24] < 3'd3, data, r[31:28]);
    endtask

    task automatic run_flush();
        int dirty_lines;
        dirty_lines = 0;
        for (int s = 0; s < `DCACHE_NO_OF_SETS; s++) begin
            if (exp_valid[s] && exp_dirty[s]) begin
                dirty_lines++;
            end
        end
        seen_we.delete();
        seen_addr.delete();
        seen_wdata.delete();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        while (!flush_done) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (!flush_done) else fail_plain("flush_done stayed high for more than one cycle");
        assert (seen_addr.size() == dirty_lines)
            else fail_value("flush write-backs", 128'(dirty_lines), 128'(seen_addr.size()));
        for (int i = 0; i < seen_addr.size(); i++) begin
            assert (seen_we[i] && seen_wdata[i] == shadow_line(seen_addr[i]))
                else fail_value($sformatf("flush line @%h", seen_addr[i]),
                                shadow_line(seen_addr[i]), seen_wdata[i]);
        end
        for (int s = 0; s < `DCACHE_NO_OF_SETS; s++) begin
            exp_valid[s] = 1'b0;
            exp_dirty[s] = 1'b0;
        end
        for (int l = 0; l < MODEL_LINES; l++) begin
            peek_addr = dcache_addr_t'(l * 16);
            #1;
            assert (peek_line == shadow_line(peek_addr))
                else fail_value($sformatf("memory image line %0d", l),
                                shadow_line(peek_addr), peek_line);
        end
        @(posedge clk);
        #1;
    endtask

    // Credit rules on both sides
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req_valid) begin
                assert (mem_pending == 0)
                    else fail_plain("memory request issued while a response was outstanding");
                seen_we.push_back(mem_we);
                seen_addr.push_back(mem_addr);
                seen_wdata.push_back(mem_wdata);
                mem_pending++;
            end
            if (mem_rsp_valid) begin
                mem_pending--;
            end
            if (lsu_rsp_valid) begin
                rsp_count++;
                assert (rsp_count <= req_count)
                    else fail_plain("cache returned more responses than requests");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_plain("watchdog expired before the test sequence finished");
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        lsu_req_valid = 1'b0;
        lsu_addr      = '0;
        lsu_we        = 1'b0;
        lsu_wdata     = '0;
        lsu_sel       = '0;
        flush         = 1'b0;
        peek_addr     = '0;
        req_count     = 0;
        rsp_count     = 0;
        mem_pending   = 0;
        rng_state     = 32'h9ecf710f;
        prev_addr     = '0;
        for (int i = 0; i < MODEL_LINES * 4; i++) begin
            shadow[i] = 32'(i * 4);
        end
        for (int s = 0; s < `DCACHE_NO_OF_SETS; s++) begin
            exp_tag[s]   = '0;
            exp_valid[s] = 1'b0;
            exp_dirty[s] = 1'b0;
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            assert (!lsu_rsp_valid && !mem_req_valid && !flush_done)
                else fail_value("idle after reset", '0,
                                128'({lsu_rsp_valid, mem_req_valid, flush_done}));
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            random_access();
        end
        run_flush();
        // Everything was invalidated, so this load must refill
        do_access(prev_addr, 1'b0, '0, 4'hf);
        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            random_access();
        end
        run_flush();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/dcache_pkg.sv
common/dcache_ctrl_if.sv
dcache/dcache_datapath.sv
dcache/dcache_controller.sv
design/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ns +incdir+common \
		common/dcache_pkg.sv common/dcache_ctrl_if.sv \
		dcache/dcache_datapath.sv dcache/dcache_controller.sv \
		design/dcache_top.sv --top-module dcache_top

clean:
	rm -rf obj_dir sim.log
